// ==== hw/rv_id_pkg.sv ====
// widths, opcodes, operand selects, enums and bus structs of the decode stage
package rv_id_pkg;

  localparam int XLEN           = 64;
  localparam int INST_WD        = 32;
  localparam int GPR_ADDR_WD    = 5;
  localparam int EBREAK_ARG_REG = 10;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;

  // major opcodes
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP32     = 7'b0111011;
  localparam logic [6:0] OPC_OPIMM    = 7'b0010011;
  localparam logic [6:0] OPC_OPIMM32  = 7'b0011011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  localparam logic [INST_WD-1:0] INST_EBREAK = 32'h0010_0073;

  // alu operand selects
  localparam logic       SRC1_RS1  = 1'b0;
  localparam logic       SRC1_PC   = 1'b1;
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2; // link address pc + 4

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } alu_op_e;

  typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JAL, BR_JALR} br_kind_e;

  // encoded as the branch funct3
  typedef enum logic [2:0] {
    BF_BEQ  = 3'b000,
    BF_BNE  = 3'b001,
    BF_BLT  = 3'b100,
    BF_BGE  = 3'b101,
    BF_BLTU = 3'b110,
    BF_BGEU = 3'b111
  } brfunc_e;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    xlen_t              pc;
  } fs_to_ds_t;

  typedef struct packed {
    gpr_addr_t  rs1;
    gpr_addr_t  rs2;
    gpr_addr_t  rd;
    xlen_t      imm;
    logic       alu_src1_sel;
    logic [1:0] alu_src2_sel;
    alu_op_e    alu_op;
    logic       word_cut;     // W-type, result cut to 32 bits
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;       // load/store funct3
    br_kind_e   br_kind;
    brfunc_e    brfunc;
    logic       ebreak;
    logic       invalid;
  } dec_t;

  typedef struct packed {
    xlen_t      rs1data;
    xlen_t      rs2data;
    xlen_t      imm;
    xlen_t      pc;
    logic       alu_src1_sel;
    logic [1:0] alu_src2_sel;
    alu_op_e    alu_op;
    logic       word_cut;
    gpr_addr_t  rd;
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;
    logic       ebreak;
    logic       invalid;
  } ds_to_es_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } br_bus_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    xlen_t     wdata;
  } ws_to_rf_t;

endpackage

// ==== hw/rv_id_decoder.sv ====
// combinational RV64I instruction decoder
`timescale 1ns/10ps

module rv_id_decoder (
  input  logic [rv_id_pkg::INST_WD-1:0] i_inst,
  output rv_id_pkg::dec_t               o_dec
);
  import rv_id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  // alt selects sub / sra
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_dec              = '0;
    o_dec.rs1          = i_inst[19:15];
    o_dec.rs2          = i_inst[24:20];
    o_dec.rd           = i_inst[11:7];
    o_dec.alu_src1_sel = SRC1_RS1;
    o_dec.alu_src2_sel = SRC2_RS2;
    o_dec.alu_op       = ALU_ADD;
    o_dec.mem_op       = funct3;
    o_dec.br_kind      = BR_NONE;
    o_dec.brfunc       = BF_BEQ;
    case (opcode)
      OPC_OP, OPC_OP32: begin
        o_dec.alu_op   = alu_sel(funct3, i_inst[30]);
        o_dec.gpr_wen  = 1'b1;
        o_dec.word_cut = (opcode == OPC_OP32);
        if (funct7 == 7'h20)
          o_dec.invalid = !(funct3 == 3'b000 || funct3 == 3'b101);
        else if (funct7 != 7'h00)
          o_dec.invalid = 1'b1;
        else if (opcode == OPC_OP32)
          o_dec.invalid = !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101);
      end
      OPC_OPIMM: begin
        o_dec.imm          = imm_i;
        o_dec.alu_src2_sel = SRC2_IMM;
        o_dec.alu_op       = alu_sel(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_dec.gpr_wen      = 1'b1;
        if (funct3 == 3'b001)
          o_dec.invalid = (i_inst[31:26] != 6'h00); // 6-bit shamt
        else if (funct3 == 3'b101)
          o_dec.invalid = !(i_inst[31:26] == 6'h00 || i_inst[31:26] == 6'h10);
      end
      OPC_OPIMM32: begin
        o_dec.imm          = imm_i;
        o_dec.alu_src2_sel = SRC2_IMM;
        o_dec.alu_op       = alu_sel(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_dec.gpr_wen      = 1'b1;
        o_dec.word_cut     = 1'b1;
        if (funct3 == 3'b001)
          o_dec.invalid = (funct7 != 7'h00);
        else if (funct3 == 3'b101)
          o_dec.invalid = !(funct7 == 7'h00 || funct7 == 7'h20);
        else
          o_dec.invalid = (funct3 != 3'b000);
      end
      OPC_LUI: begin
        o_dec.imm          = imm_u;
        o_dec.alu_src2_sel = SRC2_IMM;
        o_dec.alu_op       = ALU_PASSB;
        o_dec.gpr_wen      = 1'b1;
      end
      OPC_AUIPC: begin
        o_dec.imm          = imm_u;
        o_dec.alu_src1_sel = SRC1_PC;
        o_dec.alu_src2_sel = SRC2_IMM;
        o_dec.gpr_wen      = 1'b1;
      end
      OPC_LOAD: begin
        o_dec.imm          = imm_i;
        o_dec.alu_src2_sel = SRC2_IMM;
        o_dec.mem_ren      = 1'b1;
        o_dec.gpr_wen      = 1'b1;
        o_dec.invalid      = (funct3 == 3'b111);
      end
      OPC_STORE: begin
        o_dec.imm          = imm_s;
        o_dec.alu_src2_sel = SRC2_IMM;
        o_dec.mem_wen      = 1'b1;
        o_dec.invalid      = funct3[2];
      end
      OPC_BRANCH: begin
        o_dec.imm     = imm_b;
        o_dec.br_kind = BR_COND;
        o_dec.brfunc  = brfunc_e'(funct3);
        o_dec.invalid = (funct3[2:1] == 2'b01);
      end
      OPC_JAL, OPC_JALR: begin
        o_dec.imm          = (opcode == OPC_JAL) ? imm_j : imm_i;
        o_dec.br_kind      = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        o_dec.alu_src1_sel = SRC1_PC;   // rd gets pc + 4
        o_dec.alu_src2_sel = SRC2_FOUR;
        o_dec.gpr_wen      = 1'b1;
        o_dec.invalid      = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_SYSTEM: begin
        if (i_inst == INST_EBREAK) begin
          o_dec.ebreak = 1'b1;
          o_dec.rs1    = gpr_addr_t'(EBREAK_ARG_REG); // exit code
        end else begin
          o_dec.invalid = 1'b1;
        end
      end
      default: o_dec.invalid = 1'b1;
    endcase
    // nothing may write or redirect on a bad encoding
    if (o_dec.invalid) begin
      o_dec.gpr_wen = 1'b0;
      o_dec.mem_ren = 1'b0;
      o_dec.mem_wen = 1'b0;
      o_dec.br_kind = BR_NONE;
    end
  end

endmodule

// ==== hw/rv_id_gpr.sv ====
// general register file, two async read ports and one write port
`timescale 1ns/10ps

module rv_id_gpr (
  input  logic                 i_clk,
  input  rv_id_pkg::gpr_addr_t i_raddr1,
  input  rv_id_pkg::gpr_addr_t i_raddr2,
  output rv_id_pkg::xlen_t     o_rdata1,
  output rv_id_pkg::xlen_t     o_rdata2,
  input  rv_id_pkg::ws_to_rf_t i_ws_to_rf
);
  import rv_id_pkg::*;

  xlen_t gpr_q [1:31]; // x0 has no storage

  always_ff @(posedge i_clk) begin
    if (i_ws_to_rf.wen && (i_ws_to_rf.waddr != '0)) begin
      gpr_q[i_ws_to_rf.waddr] <= i_ws_to_rf.wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : gpr_q[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : gpr_q[i_raddr2];

endmodule

// ==== hw/rv_id_ctrl.sv ====
// decode stage valid and payload registers, RAW interlock and handshake
`timescale 1ns/10ps

module rv_id_ctrl (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_fs_to_ds_valid,
  input  rv_id_pkg::fs_to_ds_t              i_fs_to_ds_bus,
  input  logic                              i_es_allowin,
  input  rv_id_pkg::gpr_addr_t              i_rs1,
  input  rv_id_pkg::gpr_addr_t              i_rs2,
  input  rv_id_pkg::gpr_addr_t              i_es_rd,
  input  rv_id_pkg::gpr_addr_t              i_ms_rd,
  input  rv_id_pkg::gpr_addr_t              i_ws_rd,
  output logic                              o_ds_allowin,
  output logic                              o_ds_go,
  output logic [rv_id_pkg::INST_WD-1:0]     o_inst,
  output rv_id_pkg::xlen_t                  o_pc
);
  import rv_id_pkg::*;

  logic      ds_valid;
  logic      ds_blocked;
  fs_to_ds_t ds_bus_q;

  // x0 is never a pending write
  function automatic logic rd_hit(input gpr_addr_t rd, input gpr_addr_t rs1,
                                  input gpr_addr_t rs2);
    return (rd != '0) && ((rd == rs1) || (rd == rs2));
  endfunction

  assign ds_blocked = rd_hit(i_es_rd, i_rs1, i_rs2)
                   || rd_hit(i_ms_rd, i_rs1, i_rs2)
                   || rd_hit(i_ws_rd, i_rs1, i_rs2);

  assign o_ds_go      = ds_valid && !ds_blocked;
  assign o_ds_allowin = !ds_valid || (!ds_blocked && i_es_allowin);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_bus_q <= i_fs_to_ds_bus;
    end
  end

  assign o_inst = ds_bus_q.inst;
  assign o_pc   = ds_bus_q.pc;

endmodule

// ==== hw/rv_id_bru.sv ====
// branch and jump resolution toward fetch
`timescale 1ns/10ps

module rv_id_bru (
  input  logic                i_go,
  input  rv_id_pkg::xlen_t    i_pc,
  input  rv_id_pkg::xlen_t    i_rs1data,
  input  rv_id_pkg::xlen_t    i_rs2data,
  input  rv_id_pkg::dec_t     i_dec,
  output rv_id_pkg::br_bus_t  o_br_bus
);
  import rv_id_pkg::*;

  logic  cond_hit;
  logic  is_jalr;
  xlen_t base;
  xlen_t sum;

  always_comb begin
    case (i_dec.brfunc)
      BF_BEQ:  cond_hit = (i_rs1data == i_rs2data);
      BF_BNE:  cond_hit = (i_rs1data != i_rs2data);
      BF_BLT:  cond_hit = ($signed(i_rs1data) <  $signed(i_rs2data));
      BF_BGE:  cond_hit = ($signed(i_rs1data) >= $signed(i_rs2data));
      BF_BLTU: cond_hit = (i_rs1data <  i_rs2data);
      BF_BGEU: cond_hit = (i_rs1data >= i_rs2data);
      default: cond_hit = 1'b0;
    endcase
  end

  assign is_jalr = (i_dec.br_kind == BR_JALR);
  assign base    = is_jalr ? i_rs1data : i_pc;
  assign sum     = base + i_dec.imm;

  assign o_br_bus.target = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum; // jalr drops bit 0
  assign o_br_bus.taken  = i_go && ((i_dec.br_kind == BR_JAL) || is_jalr
                                    || ((i_dec.br_kind == BR_COND) && cond_hit));

endmodule

// ==== hw/rv_id_stage.sv ====
// decode stage top, control, decoder, register file, branch unit and bundle
`timescale 1ns/10ps

module rv_id_stage (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // from fetch
  input  logic                  i_fs_to_ds_valid,
  input  rv_id_pkg::fs_to_ds_t  i_fs_to_ds_bus,
  output logic                  o_ds_allowin,
  // to execute
  output logic                  o_ds_to_es_valid,
  output rv_id_pkg::ds_to_es_t  o_ds_to_es_bus,
  input  logic                  i_es_allowin,
  // redirect to fetch
  output rv_id_pkg::br_bus_t    o_br_bus,
  // writeback port
  input  rv_id_pkg::ws_to_rf_t  i_ws_to_rf_bus,
  // pending destinations, zero when none
  input  rv_id_pkg::gpr_addr_t  i_es_rd,
  input  rv_id_pkg::gpr_addr_t  i_ms_rd,
  input  rv_id_pkg::gpr_addr_t  i_ws_rd
);
  import rv_id_pkg::*;

  logic [INST_WD-1:0] ds_inst;
  xlen_t              ds_pc;
  xlen_t              rs1data;
  xlen_t              rs2data;
  dec_t               dec;
  logic               ds_go;

  rv_id_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds_bus   (i_fs_to_ds_bus),
    .i_es_allowin     (i_es_allowin),
    .i_rs1            (dec.rs1),
    .i_rs2            (dec.rs2),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_go          (ds_go),
    .o_inst           (ds_inst),
    .o_pc             (ds_pc)
  );

  rv_id_decoder u_dec (
    .i_inst (ds_inst),
    .o_dec  (dec)
  );

  rv_id_gpr u_gpr (
    .i_clk      (i_clk),
    .i_raddr1   (dec.rs1),
    .i_raddr2   (dec.rs2),
    .o_rdata1   (rs1data),
    .o_rdata2   (rs2data),
    .i_ws_to_rf (i_ws_to_rf_bus)
  );

  rv_id_bru u_bru (
    .i_go      (ds_go),
    .i_pc      (ds_pc),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .i_dec     (dec),
    .o_br_bus  (o_br_bus)
  );

  assign o_ds_to_es_valid = ds_go;

  assign o_ds_to_es_bus.rs1data      = rs1data;
  assign o_ds_to_es_bus.rs2data      = rs2data;
  assign o_ds_to_es_bus.imm          = dec.imm;
  assign o_ds_to_es_bus.pc           = ds_pc;
  assign o_ds_to_es_bus.alu_src1_sel = dec.alu_src1_sel;
  assign o_ds_to_es_bus.alu_src2_sel = dec.alu_src2_sel;
  assign o_ds_to_es_bus.alu_op       = dec.alu_op;
  assign o_ds_to_es_bus.word_cut     = dec.word_cut;
  assign o_ds_to_es_bus.rd           = dec.rd;
  assign o_ds_to_es_bus.gpr_wen      = dec.gpr_wen;
  assign o_ds_to_es_bus.mem_ren      = dec.mem_ren;
  assign o_ds_to_es_bus.mem_wen      = dec.mem_wen;
  assign o_ds_to_es_bus.mem_op       = dec.mem_op;
  assign o_ds_to_es_bus.ebreak       = dec.ebreak;
  assign o_ds_to_es_bus.invalid      = dec.invalid;

endmodule

// ==== test/rv_id_asserts.sv ====
// concurrent checks on the decode stage handshake and interlock
`timescale 1ns/10ps

module rv_id_asserts (
  input logic                              i_clk,
  input logic                              i_rst_n,
  input logic                              i_es_allowin,
  input rv_id_pkg::gpr_addr_t              i_es_rd,
  input rv_id_pkg::gpr_addr_t              i_ms_rd,
  input rv_id_pkg::gpr_addr_t              i_ws_rd,
  input logic                              o_ds_go,
  input logic [rv_id_pkg::INST_WD-1:0]     o_inst,
  input rv_id_pkg::xlen_t                  o_pc
);
  import rv_id_pkg::*;

  gpr_addr_t src1;
  gpr_addr_t src2;
  logic      hazard;

  // sources straight from the held instruction word
  assign src1 = (o_inst == INST_EBREAK) ? gpr_addr_t'(EBREAK_ARG_REG) : o_inst[19:15];
  assign src2 = o_inst[24:20];

  assign hazard = ((i_es_rd != '0) && (i_es_rd == src1 || i_es_rd == src2))
               || ((i_ms_rd != '0) && (i_ms_rd == src1 || i_ms_rd == src2))
               || ((i_ws_rd != '0) && (i_ws_rd == src1 || i_ws_rd == src2));

  no_go_on_hazard: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_ds_go |-> !hazard)
    else $error("instruction left while a source register was pending");

  hold_under_backpressure: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_go && !i_es_allowin) |=> ($stable(o_inst) && $stable(o_pc)))
    else $error("held instruction changed while execute refused it");

  valid_held_under_backpressure: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_go && !i_es_allowin) |=> (o_ds_go || hazard))
    else $error("stalled instruction lost its valid while execute refused it");

endmodule

bind rv_id_ctrl rv_id_asserts u_asserts (.*);

// ==== test/rv_id_tb.sv ====
// testbench for the decode stage, with stimulus, reference model and checker
`timescale 1ns/10ps

module rv_id_tb;
  import rv_id_pkg::*;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      fs_valid;
  fs_to_ds_t fs_bus;
  logic      es_allowin;
  ws_to_rf_t ws_bus;
  gpr_addr_t es_rd;
  gpr_addr_t ms_rd;
  gpr_addr_t ws_rd;
  logic      ds_allowin;
  logic      ds_to_es_valid;
  ds_to_es_t ds_to_es_bus;
  br_bus_t   br_bus;

  xlen_t     shadow [32];        // expected register contents
  logic      held_valid;
  fs_to_ds_t held;
  int        errors;
  int        leave_count;

  rv_id_stage u_dut (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds_bus   (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus   (ds_to_es_bus),
    .i_es_allowin     (es_allowin),
    .o_br_bus         (br_bus),
    .i_ws_to_rf_bus   (ws_bus),
    .i_es_rd          (es_rd),
    .i_ms_rd          (ms_rd),
    .i_ws_rd          (ws_rd)
  );

  always #10 clk = ~clk;

  task automatic check(input string name, input logic [299:0] exp, input logic [299:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // source registers as the interlock sees them
  function automatic void src_regs(input logic [31:0] inst, output gpr_addr_t ra,
                                   output gpr_addr_t rb);
    ra = inst[19:15];
    rb = inst[24:20];
    if (inst == 32'h0010_0073) ra = 5'd10;
  endfunction

  function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'd0:    op = alt ? ALU_SUB : ALU_ADD;
      3'd1:    op = ALU_SLL;
      3'd2:    op = ALU_SLT;
      3'd3:    op = ALU_SLTU;
      3'd4:    op = ALU_XOR;
      3'd5:    op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  function automatic ds_to_es_t ref_bundle(input logic [31:0] inst, input xlen_t pc,
                                           input logic go, output br_bus_t br);
    ds_to_es_t e;
    gpr_addr_t ra;
    gpr_addr_t rb;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       cond;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      sum;
    opc   = inst[6:0];
    f3    = inst[14:12];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    src_regs(inst, ra, rb);
    e         = '0;
    e.rs1data = shadow[ra];
    e.rs2data = shadow[rb];
    e.pc      = pc;
    e.rd      = inst[11:7];
    e.mem_op  = f3;
    e.alu_op  = ALU_ADD;
    br        = '0;
    cond      = 1'b0;
    case (opc)
      7'b0110011, 7'b0111011: begin
        e.alu_op   = ref_alu(f3, inst[30]);
        e.gpr_wen  = 1'b1;
        e.word_cut = opc[3];
      end
      7'b0010011, 7'b0011011: begin
        e.imm          = imm_i;
        e.alu_src2_sel = 2'd1;
        e.alu_op       = ref_alu(f3, (f3 == 3'd5) && inst[30]);
        e.gpr_wen      = 1'b1;
        e.word_cut     = opc[3];
      end
      7'b0110111, 7'b0010111: begin
        e.imm          = {{32{inst[31]}}, inst[31:12], 12'h000};
        e.alu_src2_sel = 2'd1;
        e.alu_src1_sel = !opc[5];           // auipc adds pc
        e.alu_op       = opc[5] ? ALU_PASSB : ALU_ADD;
        e.gpr_wen      = 1'b1;
      end
      7'b0000011: begin
        e.imm          = imm_i;
        e.alu_src2_sel = 2'd1;
        e.mem_ren      = 1'b1;
        e.gpr_wen      = 1'b1;
      end
      7'b0100011: begin
        e.imm          = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        e.alu_src2_sel = 2'd1;
        e.mem_wen      = 1'b1;
      end
      7'b1100011: begin
        e.imm = imm_b;
        case (f3)
          3'd0:    cond = (e.rs1data == e.rs2data);
          3'd1:    cond = (e.rs1data != e.rs2data);
          3'd4:    cond = ($signed(e.rs1data) < $signed(e.rs2data));
          3'd5:    cond = ($signed(e.rs1data) >= $signed(e.rs2data));
          3'd6:    cond = (e.rs1data < e.rs2data);
          default: cond = (e.rs1data >= e.rs2data);
        endcase
        br.target = pc + imm_b;
      end
      7'b1101111, 7'b1100111: begin
        e.imm = opc[3] ? {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}
                       : imm_i;
        e.alu_src1_sel = 1'b1;
        e.alu_src2_sel = 2'd2;
        e.gpr_wen      = 1'b1;
        cond           = 1'b1;
        sum            = (opc[3] ? pc : e.rs1data) + e.imm;
        br.target      = opc[3] ? sum : {sum[63:1], 1'b0};
      end
      default: begin
        if (inst == 32'h0010_0073) e.ebreak = 1'b1;
        else e.invalid = 1'b1;
      end
    endcase
    br.taken = go && cond;
    return e;
  endfunction

  function automatic logic hit(input gpr_addr_t rd, input gpr_addr_t ra, input gpr_addr_t rb);
    return (rd != 5'd0) && ((rd == ra) || (rd == rb));
  endfunction

  // compares the stage outputs with the reference model at each falling edge
  always @(negedge clk) begin
    gpr_addr_t ra;
    gpr_addr_t rb;
    logic      haz;
    logic      exp_go;
    br_bus_t   exp_br;
    ds_to_es_t exp_bus;
    if (rst_n) begin
      src_regs(held.inst, ra, rb);
      haz    = held_valid && (hit(es_rd, ra, rb) || hit(ms_rd, ra, rb) || hit(ws_rd, ra, rb));
      exp_go = held_valid && !haz;
      check("ds_to_es_valid", 300'(exp_go), 300'(ds_to_es_valid));
      check("ds_allowin", 300'(!held_valid || (!haz && es_allowin)), 300'(ds_allowin));
      if (exp_go) begin
        exp_bus = ref_bundle(held.inst, held.pc, exp_go, exp_br);
        check("ds_to_es_bus", 300'(exp_bus), 300'(ds_to_es_bus));
        check("br_taken", 300'(exp_br.taken), 300'(br_bus.taken));
        // target only defined for branches and jumps
        if (held.inst[6:0] == OPC_BRANCH || held.inst[6:0] == OPC_JAL
            || held.inst[6:0] == OPC_JALR)
          check("br_target", 300'(exp_br.target), 300'(br_bus.target));
        if (es_allowin) leave_count++;
      end else begin
        check("br_taken_idle", 300'(1'b0), 300'(br_bus.taken));
      end
      if (ws_bus.wen && ws_bus.waddr != 5'd0) shadow[ws_bus.waddr] = ws_bus.wdata;
      if (fs_valid && ds_allowin) held = fs_bus;
      if (ds_allowin) held_valid = fs_valid;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input gpr_addr_t a, input xlen_t d);
    ws_bus = '{wen: 1'b1, waddr: a, wdata: d};
    step();
    ws_bus.wen = 1'b0;
  endtask

  task automatic issue(input logic [31:0] inst, input xlen_t pc);
    int n;
    n        = 0;
    fs_valid = 1'b1;
    fs_bus   = '{inst: inst, pc: pc};
    @(negedge clk);
    while (!ds_allowin) begin
      n++;
      if (n > 50) timeout("the stage to accept an instruction");
      @(negedge clk);
    end
    step();
    fs_valid = 1'b0;
  endtask

  task automatic wait_leave();
    int n;
    n = 0;
    @(negedge clk);
    while (!(ds_to_es_valid && es_allowin)) begin
      n++;
      if (n > 50) timeout("the instruction to leave toward execute");
      @(negedge clk);
    end
    step();
  endtask

  function automatic logic [31:0] rand_inst();
    logic [4:0]  a;
    logic [4:0]  b;
    logic [4:0]  d;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    a   = 5'($urandom % 32);
    b   = 5'($urandom % 32);
    d   = 5'($urandom % 32);
    f3  = 3'($urandom % 8);
    imm = 12'($urandom);
    alt = 1'($urandom % 2);
    case ($urandom % 7)
      0: return r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, b, a, f3, d, OPC_OP);
      1: begin
        f3 = (f3 < 3'd3) ? 3'd0 : ((f3 < 3'd5) ? 3'd1 : 3'd5);
        return r_type((alt && f3 != 3'd1) ? 7'h20 : 7'h00, b, a, f3, d, OPC_OP32);
      end
      2: begin
        if (f3 == 3'd1) imm[11:6] = 6'h00;
        if (f3 == 3'd5) imm[11:6] = alt ? 6'h10 : 6'h00;
        return i_type(imm, a, f3, d, OPC_OPIMM);
      end
      3: begin
        f3 = (f3 < 3'd3) ? 3'd0 : ((f3 < 3'd5) ? 3'd1 : 3'd5);
        if (f3 != 3'd0) imm[11:5] = (alt && f3 == 3'd5) ? 7'h20 : 7'h00;
        return i_type(imm, a, f3, d, OPC_OPIMM32);
      end
      4: return {20'($urandom), d, alt ? OPC_LUI : OPC_AUIPC};
      5: return i_type(imm, a, (f3 == 3'd7) ? 3'd6 : f3, d, OPC_LOAD);
      default: return {imm[11:5], b, a, {1'b0, f3[1:0]}, imm[4:0], OPC_STORE};
    endcase
  endfunction

  initial begin
    int          cnt0;
    logic [31:0] inst;
    rst_n      = 1'b0;
    fs_valid   = 1'b0;
    fs_bus     = '0;
    es_allowin = 1'b1;
    ws_bus     = '0;
    es_rd      = '0;
    ms_rd      = '0;
    ws_rd      = '0;
    held_valid = 1'b0;
    held       = '0;
    errors     = 0;
    leave_count = 0;
    foreach (shadow[i]) shadow[i] = '0;
    void'($urandom(44));
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("reset_valid", 300'(1'b0), 300'(ds_to_es_valid));
    check("reset_taken", 300'(1'b0), 300'(br_bus.taken));
    check("reset_allowin", 300'(1'b1), 300'(ds_allowin));
    step();

    // random register contents and random non-branch instructions
    for (int r = 1; r < 32; r++) write_reg(5'(r), {32'($urandom), 32'($urandom)});
    for (int k = 0; k < 60; k++) begin
      issue(rand_inst(), {32'($urandom), 32'($urandom)} & ~64'h3);
      wait_leave();
    end
    issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd3, OPC_OP), 64'h100);   // reads x0 on both ports
    wait_leave();

    // interlock against each later stage on each source
    inst = r_type(7'h00, 5'd5, 5'd4, 3'd0, 5'd3, OPC_OP);
    for (int k = 0; k < 6; k++) begin
      case (k % 3)
        0: es_rd = (k < 3) ? 5'd4 : 5'd5;
        1: ms_rd = (k < 3) ? 5'd4 : 5'd5;
        default: ws_rd = (k < 3) ? 5'd4 : 5'd5;
      endcase
      issue(inst, 64'h200);
      repeat (3) @(negedge clk);
      check("interlock_valid", 300'(1'b0), 300'(ds_to_es_valid));
      check("interlock_allowin", 300'(1'b0), 300'(ds_allowin));
      step();
      es_rd = '0;
      ms_rd = '0;
      ws_rd = '0;
      wait_leave();
    end

    // conditional branches, jal and jalr
    write_reg(5'd5, -64'sd5);
    write_reg(5'd6, 64'd3);
    write_reg(5'd7, -64'sd5);
    write_reg(5'd8, 64'h1001);
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        issue(b_type(13'h0040, 5'd6, 5'd5, 3'(f)), 64'h1000);
        wait_leave();
        issue(b_type(13'h1ff0, 5'd7, 5'd5, 3'(f)), 64'h1000);
        wait_leave();
        issue(b_type(13'h0040, 5'd5, 5'd6, 3'(f)), 64'h1000);
        wait_leave();
      end
    end
    issue({20'h00800, 5'd1, OPC_JAL}, 64'h2000);
    wait_leave();
    issue(i_type(12'h004, 5'd8, 3'd0, 5'd1, OPC_JALR), 64'h2000);  // odd sum
    wait_leave();

    // back-pressure, then back-to-back flow
    es_allowin = 1'b0;
    issue(r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd9, OPC_OP), 64'h3000);
    fs_valid = 1'b1;
    fs_bus   = '{inst: i_type(12'h011, 5'd2, 3'd0, 5'd9, OPC_OPIMM), pc: 64'h3004};
    repeat (4) @(negedge clk);
    check("stall_allowin", 300'(1'b0), 300'(ds_allowin));
    step();
    cnt0       = leave_count;
    es_allowin = 1'b1;
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      check("b2b_allowin", 300'(1'b1), 300'(ds_allowin));
      step();
      fs_bus = '{inst: rand_inst(), pc: 64'h3008 + 64'(4 * k)};
    end
    @(negedge clk);
    step();
    fs_valid = 1'b0;
    wait_leave();
    check("b2b_count", 300'(6), 300'(leave_count - cnt0));

    // ebreak waits for x10, then an unknown opcode
    ws_rd = 5'd10;
    issue(32'h0010_0073, 64'h4000);
    repeat (3) @(negedge clk);
    check("ebreak_blocked", 300'(1'b0), 300'(ds_to_es_valid));
    step();
    write_reg(5'd10, 64'h0000_0000_0000_002a);
    ws_rd = '0;
    wait_leave();
    issue(32'h0000_007f, 64'h4004);
    wait_leave();

    if (errors == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "checks failed");
    end
  end

endmodule

// ==== rv_id.f ====
hw/rv_id_pkg.sv
hw/rv_id_decoder.sv
hw/rv_id_gpr.sv
hw/rv_id_ctrl.sv
hw/rv_id_bru.sv
hw/rv_id_stage.sv
test/rv_id_asserts.sv
test/rv_id_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv \
  -f rv_id.f \
  --top-module rv_id_tb \
  -Mdir obj_dir \
  -o rv_id_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/rv_id_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
